// File: drac_settings.svh
/* DRAC fetch build parameters */
`ifndef DRAC_SETTINGS_SVH
`define DRAC_SETTINGS_SVH

// Virtual address width (Sv39 plus sign bit)
`define DRAC_ADDR_W 40

// One ICache line holds four instructions
`define DRAC_LINE_W 128

`define DRAC_INSTR_W 32 // RV64 base encoding, no compressed

// Cycles an open ICache request may wait for ack
`define DRAC_FETCH_TIMEOUT 16

`endif

// File: drac_pkg.sv
/* DRAC core-side types */
`include "drac_settings.svh"

package drac_pkg;

    // Virtual address as seen by fetch
    typedef logic [`DRAC_ADDR_W-1:0] addr_t;

    // Fetch unit states
    typedef enum logic [2:0] {
        FETCH_IDLE    = 3'd0, // Out of reset, wait ack low
        FETCH_REQ     = 3'd1, // ICache request open
        FETCH_RELEASE = 3'd2, // Req dropped, wait ack low
        FETCH_DELIVER = 3'd3, // Instruction held toward decode
        FETCH_FAULT   = 3'd4  // Parked until a redirect
    } fetch_state_e;

    // Exception cause carried with each instruction
    typedef enum logic [1:0] {
        XCPT_NONE               = 2'd0,
        XCPT_INSTR_PAGE_FAULT   = 2'd1, // TLB flagged the access
        XCPT_INSTR_ACCESS_FAULT = 2'd2  // ICache never answered
    } xcpt_cause_e;

    // Fetch to decode payload
    typedef struct packed {
        addr_t                    pc;
        logic [`DRAC_INSTR_W-1:0] instr; // Zero on access fault
        xcpt_cause_e              cause;
    } fetch_out_t;

endpackage

// File: drac_mem_pkg.sv
/* DRAC memory-side types */
`include "drac_settings.svh"

package drac_mem_pkg;

    import drac_pkg::*;

    // Full ICache line
    typedef logic [`DRAC_LINE_W-1:0] icache_line_t;

    // CPU to ICache request
    typedef struct packed {
        logic  req;   // Four-phase request
        addr_t vaddr; // Held stable while req is high
    } req_cpu_icache_t;

    // ICache to CPU response, flags valid only with ack
    typedef struct packed {
        logic         ack;
        icache_line_t data;
        logic         tlb_miss;   // Replay same PC
        logic         tlb_xcpt;   // Instruction page fault
        logic         invalidate; // PTW kill of this fetch
    } req_icache_cpu_t;

endpackage

// File: pc_gen.sv
/* Program counter */
`timescale 1ns/1ps

module pc_gen
    import drac_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  soft_rst_n_i,
    input  addr_t reset_addr_i,
    input  logic  csr_xcpt_i,
    input  addr_t csr_evec_i,
    input  logic  pc_update_i,
    input  addr_t pc_value_i,
    input  logic  advance_i,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_d;

    // Highest priority first
    always_comb begin
        pc_d = pc_q;
        if (!soft_rst_n_i) begin
            pc_d = reset_addr_i; // Soft reset back to boot address
        end else if (csr_xcpt_i) begin
            pc_d = csr_evec_i; // Trap vector
        end else if (pc_update_i) begin
            pc_d = pc_value_i; // External fetch PC port
        end else if (advance_i) begin
            pc_d = pc_q + addr_t'(4);
        end
    end

    // Reset address is a strap, stable around reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: fetch_timer.sv
/* ICache request timeout counter */
`timescale 1ns/1ps
`include "drac_settings.svh"

module fetch_timer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic run_i,
    output logic timeout_o
);

    localparam int unsigned LIMIT = `DRAC_FETCH_TIMEOUT;
    localparam int unsigned CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] count_q;

    // Count waiting cycles, hold at the limit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0; // Ack came or no request open
        end else if (count_q != LIMIT[CNT_W-1:0]) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Only meaningful while a request waits
    assign timeout_o = run_i & (count_q == LIMIT[CNT_W-1:0]);

endmodule

// File: fetch_fsm.sv
/* Fetch control FSM */
`timescale 1ns/1ps

module fetch_fsm
    import drac_pkg::*;
    import drac_mem_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            soft_rst_n_i,
    input  addr_t           pc_i,
    input  logic            redirect_i,
    input  req_icache_cpu_t req_icache_cpu_i,
    input  logic            timeout_i,
    input  logic            deliver_done_i,
    output req_cpu_icache_t req_cpu_icache_o,
    output logic            timer_run_o,
    output logic            capture_o,
    output xcpt_cause_e     cause_o,
    output logic            advance_o
);

    fetch_state_e state_q, state_d;
    addr_t        vaddr_q, vaddr_d; // Address of the open request
    logic         stale_q, stale_d; // Redirect seen since request start
    logic         fault_q, fault_d; // Current delivery carries a fault
    logic         redirected;
    logic         ack;

    assign ack        = req_icache_cpu_i.ack;
    assign redirected = stale_q | redirect_i;

    always_comb begin
        state_d   = state_q;
        vaddr_d   = vaddr_q;
        fault_d   = fault_q;
        capture_o = 1'b0;
        cause_o   = XCPT_NONE;
        advance_o = 1'b0;
        case (state_q)
            FETCH_IDLE: begin
                if (!ack) begin
                    state_d = FETCH_REQ;
                    vaddr_d = pc_i;
                end
            end
            FETCH_REQ: begin
                if (ack) begin
                    // Stale line, PTW kill or TLB miss, fetch current PC again
                    if (redirected || req_icache_cpu_i.invalidate || req_icache_cpu_i.tlb_miss) begin
                        state_d = FETCH_RELEASE;
                    end else begin
                        capture_o = 1'b1;
                        cause_o   = req_icache_cpu_i.tlb_xcpt ? XCPT_INSTR_PAGE_FAULT : XCPT_NONE;
                        fault_d   = req_icache_cpu_i.tlb_xcpt;
                        state_d   = FETCH_DELIVER;
                    end
                end else if (timeout_i) begin
                    if (redirected) begin
                        state_d = FETCH_RELEASE; // Nobody wants this PC anymore
                    end else begin
                        capture_o = 1'b1;
                        cause_o   = XCPT_INSTR_ACCESS_FAULT;
                        fault_d   = 1'b1;
                        state_d   = FETCH_DELIVER;
                    end
                end
            end
            FETCH_RELEASE: begin
                if (!ack) begin // Previous handshake fully closed
                    state_d = FETCH_REQ;
                    vaddr_d = pc_i;
                end
            end
            FETCH_DELIVER: begin
                if (deliver_done_i) begin
                    advance_o = ~fault_q & ~stale_q; // Redirected PC is already new
                    if (fault_q && !redirected) begin
                        state_d = FETCH_FAULT;
                    end else begin
                        state_d = FETCH_RELEASE;
                    end
                end
            end
            FETCH_FAULT: begin
                if (redirect_i) state_d = FETCH_RELEASE;
            end
            default: state_d = FETCH_IDLE;
        endcase
        if (!soft_rst_n_i) begin
            state_d = FETCH_IDLE;
            fault_d = 1'b0;
        end
    end

    // Fresh request starts clean, except for a redirect in the same cycle
    assign stale_d = (state_d == FETCH_REQ && state_q != FETCH_REQ) ? redirect_i : redirected;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FETCH_IDLE;
            stale_q <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            state_q <= state_d;
            stale_q <= stale_d;
            fault_q <= fault_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
    end

    assign req_cpu_icache_o.req   = (state_q == FETCH_REQ);
    assign req_cpu_icache_o.vaddr = vaddr_q;
    assign timer_run_o            = (state_q == FETCH_REQ) & ~ack; // Waiting on ICache

endmodule

// File: fetch_buffer.sv
/* Fetch output buffer */
`timescale 1ns/1ps
`include "drac_settings.svh"

module fetch_buffer
    import drac_pkg::*;
    import drac_mem_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         capture_i,
    input  addr_t        pc_i,
    input  icache_line_t line_i,
    input  xcpt_cause_e  cause_i,
    input  logic         instr_ack_i,
    output logic         instr_valid_o,
    output fetch_out_t   instr_o,
    output logic         deliver_done_o
);

    logic [`DRAC_INSTR_W-1:0] word_sel;
    fetch_out_t               instr_q;
    logic                     valid_q;
    logic                     drain_q; // Valid dropped, wait consumer ack low

    // Word within the line from PC bits 3:2
    always_comb begin
        if (cause_i == XCPT_INSTR_ACCESS_FAULT) begin
            word_sel = '0; // No line on access fault
        end else begin
            word_sel = line_i[pc_i[3:2]*`DRAC_INSTR_W +: `DRAC_INSTR_W];
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            instr_q.pc    <= pc_i;
            instr_q.instr <= word_sel;
            instr_q.cause <= cause_i;
        end
    end

    // Four-phase toward decode
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            drain_q <= 1'b0;
        end else begin
            if (capture_i) begin
                valid_q <= 1'b1;
            end else if (valid_q && instr_ack_i) begin
                valid_q <= 1'b0;
            end
            if (valid_q && instr_ack_i) begin
                drain_q <= 1'b1;
            end else if (!instr_ack_i) begin
                drain_q <= 1'b0;
            end
        end
    end

    assign instr_valid_o  = valid_q;
    assign instr_o        = instr_q;
    assign deliver_done_o = drain_q & ~instr_ack_i; // Ack fell, handshake closed

endmodule

// File: datapath.sv
/* DRAC fetch datapath */
`timescale 1ns/1ps

module datapath
    import drac_pkg::*;
    import drac_mem_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            soft_rst_n_i,
    input  addr_t           reset_addr_i,
    input  logic            csr_xcpt_i,
    input  addr_t           csr_evec_i,
    input  logic            io_fetch_pc_update_i,
    input  addr_t           io_fetch_pc_value_i,
    input  req_icache_cpu_t req_icache_cpu_i,
    input  logic            instr_ack_i,
    output req_cpu_icache_t req_cpu_icache_o,
    output logic            instr_valid_o,
    output fetch_out_t      instr_o
);

    addr_t           pc;
    logic            redirect;
    logic            advance;
    logic            timer_run;
    logic            timeout;
    logic            capture;
    logic            deliver_done;
    xcpt_cause_e     cause;
    req_cpu_icache_t req_cpu_icache;

    // Any source that moves the PC off its sequential path
    assign redirect = csr_xcpt_i | io_fetch_pc_update_i;

    pc_gen pc_gen_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .soft_rst_n_i (soft_rst_n_i),
        .reset_addr_i (reset_addr_i),
        .csr_xcpt_i   (csr_xcpt_i),
        .csr_evec_i   (csr_evec_i),
        .pc_update_i  (io_fetch_pc_update_i),
        .pc_value_i   (io_fetch_pc_value_i),
        .advance_i    (advance),
        .pc_o         (pc)
    );

    fetch_fsm fetch_fsm_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .soft_rst_n_i     (soft_rst_n_i),
        .pc_i             (pc),
        .redirect_i       (redirect),
        .req_icache_cpu_i (req_icache_cpu_i),
        .timeout_i        (timeout),
        .deliver_done_i   (deliver_done),
        .req_cpu_icache_o (req_cpu_icache),
        .timer_run_o      (timer_run),
        .capture_o        (capture),
        .cause_o          (cause),
        .advance_o        (advance)
    );

    fetch_timer fetch_timer_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (timer_run),
        .timeout_o (timeout)
    );

    // PC of the buffered word is the requested address, not the live PC
    fetch_buffer fetch_buffer_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .capture_i      (capture),
        .pc_i           (req_cpu_icache.vaddr),
        .line_i         (req_icache_cpu_i.data),
        .cause_i        (cause),
        .instr_ack_i    (instr_ack_i),
        .instr_valid_o  (instr_valid_o),
        .instr_o        (instr_o),
        .deliver_done_o (deliver_done)
    );

    assign req_cpu_icache_o = req_cpu_icache;

endmodule

// File: top_drac.sv
/* DRAC core top, fetch side */
`timescale 1ns/1ps

module top_drac
    import drac_pkg::*;
    import drac_mem_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         soft_rst_n_i,
    input  addr_t        reset_addr_i,
    // CSR
    input  logic         csr_xcpt_i,
    input  addr_t        csr_evec_i,
    // ICache and TLB
    input  logic         icache_ack_i,
    input  icache_line_t icache_line_i,
    input  logic         tlb_miss_i,
    input  logic         tlb_xcpt_if_i,
    input  logic         ptw_invalidate_i,
    // External fetch PC
    input  logic         io_fetch_pc_update_i,
    input  addr_t        io_fetch_pc_value_i,
    // Decode side
    input  logic         instr_ack_i,
    output logic         icache_req_o,
    output addr_t        icache_vaddr_o,
    output logic         instr_valid_o,
    output fetch_out_t   instr_o
);

    req_icache_cpu_t req_icache_cpu;
    req_cpu_icache_t req_cpu_icache;

    // SoC wires into the response struct
    assign req_icache_cpu.ack        = icache_ack_i;
    assign req_icache_cpu.data       = icache_line_i;
    assign req_icache_cpu.tlb_miss   = tlb_miss_i;
    assign req_icache_cpu.tlb_xcpt   = tlb_xcpt_if_i;
    assign req_icache_cpu.invalidate = ptw_invalidate_i;

    datapath datapath_i (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .soft_rst_n_i         (soft_rst_n_i),
        .reset_addr_i         (reset_addr_i),
        .csr_xcpt_i           (csr_xcpt_i),
        .csr_evec_i           (csr_evec_i),
        .io_fetch_pc_update_i (io_fetch_pc_update_i),
        .io_fetch_pc_value_i  (io_fetch_pc_value_i),
        .req_icache_cpu_i     (req_icache_cpu),
        .instr_ack_i          (instr_ack_i),
        .req_cpu_icache_o     (req_cpu_icache),
        .instr_valid_o        (instr_valid_o),
        .instr_o              (instr_o)
    );

    assign icache_req_o   = req_cpu_icache.req; // Request struct back to flat SoC ports
    assign icache_vaddr_o = req_cpu_icache.vaddr;

endmodule

// File: tb_clk_gen.sv
/* Testbench clock */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o; // Free running, 50% duty
    end

endmodule

// File: tb_top_drac.sv
/* Fetch unit testbench */
`timescale 1ns/1ps
`include "drac_settings.svh"

module tb_top_drac
    import drac_pkg::*;
    import drac_mem_pkg::*;
();

    localparam int unsigned MAX_CYCLES = 6 * 40 * (`DRAC_FETCH_TIMEOUT + 12);
    localparam logic [31:0] WORD_KEY   = 32'h5A3C_9E17; // Line content scramble
    localparam addr_t       BOOT_ADDR  = 40'h00_8000_0000;

    logic         clk;
    logic         rst_n;
    logic         soft_rst_n;
    logic         csr_xcpt;
    addr_t        csr_evec;
    logic         icache_ack;
    icache_line_t icache_line;
    logic         tlb_miss;
    logic         tlb_xcpt_if;
    logic         ptw_invalidate;
    logic         pc_update;
    addr_t        pc_value;
    logic         instr_ack;
    logic         icache_req;
    addr_t        icache_vaddr;
    logic         instr_valid;
    fetch_out_t   instr;

    // ICache model controls, one-shot flags cleared after use
    logic miss_next;
    logic inval_next;
    logic xcpt_next;
    logic withhold_ack; // Held until the test clears it
    addr_t served_vaddr; // Request address behind the latest ICache answer

    addr_t       exp_pc; // Reference PC
    int unsigned cycles = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;

    tb_clk_gen #(.PERIOD_NS(40)) clk_gen_i (.clk_o(clk));

    top_drac top_drac_i (
        .clk_i                (clk),
        .rst_n_i              (rst_n),
        .soft_rst_n_i         (soft_rst_n),
        .reset_addr_i         (BOOT_ADDR),
        .csr_xcpt_i           (csr_xcpt),
        .csr_evec_i           (csr_evec),
        .icache_ack_i         (icache_ack),
        .icache_line_i        (icache_line),
        .tlb_miss_i           (tlb_miss),
        .tlb_xcpt_if_i        (tlb_xcpt_if),
        .ptw_invalidate_i     (ptw_invalidate),
        .io_fetch_pc_update_i (pc_update),
        .io_fetch_pc_value_i  (pc_value),
        .instr_ack_i          (instr_ack),
        .icache_req_o         (icache_req),
        .icache_vaddr_o       (icache_vaddr),
        .instr_valid_o        (instr_valid),
        .instr_o              (instr)
    );

    // Word stored at a byte address
    function automatic logic [31:0] word_at(addr_t a);
        return {a[31:2], 2'b00} ^ WORD_KEY;
    endfunction

    function automatic icache_line_t line_for(addr_t vaddr);
        icache_line_t line;
        addr_t        base;
        base = {vaddr[`DRAC_ADDR_W-1:4], 4'h0}; // Line aligned
        for (int i = 0; i < `DRAC_LINE_W / 32; i++) begin
            line[i*32 +: 32] = word_at(base + addr_t'(4 * i));
        end
        return line;
    endfunction

    function automatic addr_t rand_addr();
        addr_t a;
        a = {8'h00, $urandom()};
        a[1:0] = 2'b00; // Word aligned target
        return a;
    endfunction

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // Decode side, one four-phase transfer with random back-pressure
    task automatic receive(input addr_t pc, input logic [31:0] word,
                           input xcpt_cause_e cause, input bit check_word);
        fetch_out_t  held;
        int unsigned hold;
        while (!instr_valid) @(negedge clk);
        held = instr;
        check_value("instr_o.pc", instr.pc, pc);
        check_value("icache_vaddr_o", served_vaddr, pc); // Request that fed this delivery
        if (check_word) check_value("instr_o.instr", instr.instr, word);
        check_value("instr_o.cause", instr.cause, cause);
        hold = $urandom_range(6, 0);
        repeat (hold) begin
            @(negedge clk);
            check_value("instr_o", instr, held); // Must hold without ack
            check_flag(instr_valid && !icache_req,
                       "valid dropped or a new ICache request rose under back-pressure");
        end
        instr_ack = 1'b1;
        while (instr_valid) @(negedge clk);
        instr_ack = 1'b0;
    endtask

    task automatic next_fetch();
        receive(exp_pc, word_at(exp_pc), XCPT_NONE, 1'b1);
        exp_pc = exp_pc + addr_t'(4);
    endtask

    task automatic pulse_redirect(input logic csr, input addr_t evec,
                                  input logic upd, input addr_t val);
        csr_xcpt  = csr;
        csr_evec  = evec;
        pc_update = upd;
        pc_value  = val;
        @(negedge clk);
        csr_xcpt  = 1'b0;
        pc_update = 1'b0;
    endtask

    task automatic wait_open_req();
        while (!icache_req) @(negedge clk);
    endtask

    // Parked on a fault, nothing may move
    task automatic expect_silence(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            check_flag(!icache_req && !instr_valid,
                       "fetch activity seen while parked on a fault");
        end
    endtask

    task automatic finish_test(input string name, input int unsigned mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %0d %s ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s failed with %0d errors", tests_run, name, errors - mark);
        end
    endtask

    // ICache model, ack after 1 to 4 cycles
    initial begin : icache_model
        int unsigned delay;
        forever begin
            @(negedge clk);
            if (rst_n && icache_req && !icache_ack) begin
                if (withhold_ack) begin
                    served_vaddr = icache_vaddr;
                    while (icache_req) @(negedge clk); // Until the DUT gives up
                end else begin
                    delay = $urandom_range(3, 0);
                    repeat (delay) @(negedge clk);
                    served_vaddr   = icache_vaddr;
                    icache_line    = line_for(icache_vaddr);
                    if (miss_next || inval_next) begin
                        icache_line = ~icache_line; // Killed fetch must never reach decode
                    end
                    tlb_miss       = miss_next;
                    ptw_invalidate = inval_next;
                    tlb_xcpt_if    = xcpt_next;
                    icache_ack     = 1'b1;
                    while (icache_req) @(negedge clk);
                    icache_ack     = 1'b0;
                    tlb_miss       = 1'b0;
                    ptw_invalidate = 1'b0;
                    tlb_xcpt_if    = 1'b0;
                    miss_next      = 1'b0;
                    inval_next     = 1'b0;
                    xcpt_next      = 1'b0;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin : main
        int unsigned mark;
        addr_t       target;
        addr_t       other;
        void'($urandom(97));
        rst_n          = 1'b0;
        soft_rst_n     = 1'b1;
        csr_xcpt       = 1'b0;
        csr_evec       = '0;
        icache_ack     = 1'b0;
        icache_line    = '0;
        tlb_miss       = 1'b0;
        tlb_xcpt_if    = 1'b0;
        ptw_invalidate = 1'b0;
        pc_update      = 1'b0;
        pc_value       = '0;
        instr_ack      = 1'b0;
        miss_next      = 1'b0;
        inval_next     = 1'b0;
        xcpt_next      = 1'b0;
        withhold_ack   = 1'b0;
        served_vaddr   = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_flag(!icache_req && !instr_valid, "handshake outputs not low after reset");

        mark   = errors;
        exp_pc = BOOT_ADDR;
        repeat (24) next_fetch();
        finish_test("sequential fetch", mark);

        mark = errors;
        repeat (6) begin
            wait_open_req();
            target = rand_addr();
            pulse_redirect(1'b0, '0, 1'b1, target); // Lands on an open request
            exp_pc = target;
            next_fetch();
            next_fetch();
        end
        repeat (3) begin
            while (!instr_valid) @(negedge clk);
            target = rand_addr();
            pulse_redirect(1'b0, '0, 1'b1, target); // Held instruction still goes out
            next_fetch();
            exp_pc = target;
            next_fetch();
        end
        finish_test("fetch pc update", mark);

        mark = errors;
        for (int i = 0; i < 6; i++) begin
            wait_open_req();
            target = rand_addr();
            other  = rand_addr();
            pulse_redirect(1'b1, target, i[0], other); // CSR beats the update
            exp_pc = target;
            next_fetch();
            next_fetch();
        end
        finish_test("csr exception redirect", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            if (i[0]) inval_next = 1'b1;
            else miss_next = 1'b1;
            next_fetch(); // Same PC after the replay
            next_fetch();
        end
        finish_test("tlb miss and invalidate", mark);

        mark = errors;
        repeat (3) begin
            next_fetch();
            xcpt_next = 1'b1;
            receive(exp_pc, word_at(exp_pc), XCPT_INSTR_PAGE_FAULT, 1'b0);
            expect_silence(3 * `DRAC_FETCH_TIMEOUT);
            target = rand_addr();
            pulse_redirect(1'b0, '0, 1'b1, target);
            exp_pc = target;
            next_fetch();
        end
        finish_test("instruction page fault", mark);

        mark = errors;
        repeat (3) begin
            next_fetch();
            withhold_ack = 1'b1;
            receive(exp_pc, 32'h0, XCPT_INSTR_ACCESS_FAULT, 1'b1);
            withhold_ack = 1'b0;
            expect_silence(3 * `DRAC_FETCH_TIMEOUT);
            target = rand_addr();
            pulse_redirect(1'b1, target, 1'b0, '0);
            exp_pc = target;
            next_fetch();
            next_fetch();
        end
        finish_test("instruction access fault", mark);

        $display("tests %0d failed %0d checks %0d errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
drac_pkg.sv
drac_mem_pkg.sv
pc_gen.sv
fetch_timer.sv
fetch_fsm.sv
fetch_buffer.sv
datapath.sv
top_drac.sv
tb_clk_gen.sv
tb_top_drac.sv

// File: Makefile
# Verilator flow for the DRAC fetch unit

VERILATOR ?= verilator
TB_TOP    ?= tb_top_drac
RTL_TOP   ?= top_drac
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
